/* files.f */
+incdir+common
common/mbus_types_pkg.sv
common/host_frame_pkg.sv
design/mbus_clock_divider.sv
design/short_addr_register.sv
rx_framer/rx_word_shifter.sv
rx_framer/rx_sequencer.sv
design/ice_mbus_bridge.sv
tests/ice_mbus_bridge_properties.sv
tests/ice_mbus_bridge_tb.sv

/* Makefile */
TOP = ice_mbus_bridge_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -f files.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@grep -q "ALL CHECKS PASSED" sim.log || (echo "simulation failed, see sim.log"; exit 1)

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* tests/ice_mbus_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ice_params.svh"

module ice_mbus_bridge_tb
    import mbus_types_pkg::*;
    import host_frame_pkg::*;
();

    localparam int N_ROWS  = 12;
    localparam int N_ADDR  = 6;
    localparam int TIMEOUT = 200;

    // one controller word per row, fail_only rows carry no req
    typedef struct packed {
        mbus_word_t addr;
        mbus_word_t data;
        logic       pend;
        logic       fail;
        logic       broadcast;
        ctrl_bits_t ctrl;
        logic       fail_only;
        host_byte_t tag;
    } word_row_t;

    // short address inputs and the outputs expected after them
    typedef struct packed {
        short_addr_t override;
        short_addr_t addr_in;
        logic        write;
        logic        invalid_n;
        short_addr_t exp_addr;
        logic        exp_valid;
    } addr_row_t;

    logic        clk;
    logic        reset;
    mbus_rx_t    mbus_rx;
    host_byte_t  global_counter;
    clk_div_t    mbus_clk_div;
    short_addr_t override;
    short_addr_t addr_out;
    logic        addr_write;
    logic        addr_invalid_n;
    logic        rx_ack;
    host_out_t   host_out;
    logic        gc_inc;
    logic        mbus_clk;
    short_addr_t assigned_addr;
    logic        assigned_valid;

    word_row_t  rows [N_ROWS];
    addr_row_t  addr_rows [N_ADDR];
    // expected and received host bytes of the current frame
    host_byte_t exp_q [$];
    host_byte_t got_q [$];

    int   errors = 0;
    int   checks = 0;
    int   timeouts = 0;
    int   ack_count = 0;
    int   frame_starts = 0;
    int   frame_ends = 0;
    int   inc_count = 0;
    logic fv_prev;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ice_mbus_bridge uut (
        .clk                      (clk),
        .reset                    (reset),
        .mbus_rx                  (mbus_rx),
        .global_counter           (global_counter),
        .mbus_clk_div             (mbus_clk_div),
        .mbus_short_addr_override (override),
        .assigned_addr_out        (addr_out),
        .assigned_addr_write      (addr_write),
        .assigned_addr_invalid_n  (addr_invalid_n),
        .rx_ack                   (rx_ack),
        .host_out                 (host_out),
        .global_counter_inc       (gc_inc),
        .mbus_clk                 (mbus_clk),
        .assigned_addr            (assigned_addr),
        .assigned_addr_valid      (assigned_valid)
    );

    // byte monitor, counters settle after the edge
    always @(posedge clk) begin
        if (reset) begin
            fv_prev <= 1'b0;
        end else begin
            if (host_out.byte_valid) begin
                got_q.push_back(host_out.data);
            end
            if (host_out.frame_valid && !fv_prev) begin
                frame_starts <= frame_starts + 1;
            end
            if (!host_out.frame_valid && fv_prev) begin
                frame_ends <= frame_ends + 1;
            end
            if (rx_ack) begin
                ack_count <= ack_count + 1;
            end
            if (gc_inc) begin
                inc_count <= inc_count + 1;
            end
            fv_prev <= host_out.frame_valid;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic fill_tables();
        // addr, data, pend, fail, broadcast, ctrl, fail_only, tag
        rows[0] = '{32'h8000_1234, 32'hdead_beef, 1'b0, 1'b0, 1'b0, 2'b00, 1'b0, 8'h11};
        // three-word pended message
        rows[1] = '{32'h0001_2340, 32'h0102_0304, 1'b1, 1'b0, 1'b1, 2'b01, 1'b0, 8'h22};
        rows[2] = '{32'h0000_0000, 32'ha5a5_5a5a, 1'b1, 1'b0, 1'b0, 2'b10, 1'b0, 8'h00};
        rows[3] = '{32'h0000_0000, 32'h7777_8888, 1'b0, 1'b0, 1'b0, 2'b00, 1'b0, 8'h00};
        // failed reception, no req
        rows[4] = '{32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 2'b00, 1'b1, 8'h00};
        // random two-word messages, fail only on the closing word
        for (int k = 5; k < 11; k++) begin
            rows[k].addr      = $urandom;
            rows[k].data      = $urandom;
            rows[k].pend      = (k % 2) == 1;
            rows[k].fail      = rows[k].pend ? 1'b0 : 1'($urandom);
            rows[k].broadcast = 1'($urandom);
            rows[k].ctrl      = 2'($urandom);
            rows[k].fail_only = 1'b0;
            rows[k].tag       = 8'($urandom);
        end
        rows[11] = '{32'h0000_00f0, 32'h0bad_c0de, 1'b0, 1'b0, 1'b1, 2'b11, 1'b0, 8'hee};

        // override, addr_in, write, invalid_n, expected addr, expected valid
        addr_rows[0] = '{`ICE_SHORT_ADDR_NONE, 4'h0, 1'b0, 1'b1, `ICE_SHORT_ADDR_NONE, 1'b0};
        addr_rows[1] = '{`ICE_SHORT_ADDR_NONE, 4'h5, 1'b1, 1'b1, 4'h5, 1'b1};
        addr_rows[2] = '{4'ha, 4'h0, 1'b0, 1'b1, 4'ha, 1'b1};
        addr_rows[3] = '{`ICE_SHORT_ADDR_NONE, 4'h0, 1'b0, 1'b1, 4'h5, 1'b1};
        addr_rows[4] = '{`ICE_SHORT_ADDR_NONE, 4'h0, 1'b0, 1'b0, `ICE_SHORT_ADDR_NONE, 1'b0};
        addr_rows[5] = '{4'h3, 4'h0, 1'b0, 1'b1, 4'h3, 1'b1};
    endtask

    // messages in the word table, each closed by a row without pend
    function automatic int count_messages();
        int n;
        n = 0;
        for (int i = 0; i < N_ROWS; i++) begin
            if (!rows[i].fail_only && !rows[i].pend) begin
                n++;
            end
        end
        return n;
    endfunction

    // wait for the ack pulse, then release req and fail, pend stays
    task automatic wait_ack();
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!rx_ack && t < TIMEOUT);
        if (!rx_ack) begin
            timeouts++;
            $display("timeout: the bridge never acknowledged the word");
        end
        mbus_rx.req  <= 1'b0;
        mbus_rx.fail <= 1'b0;
    endtask

    task automatic wait_frame_end(input int ends_before);
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (frame_ends == ends_before && t < TIMEOUT);
        if (frame_ends == ends_before) begin
            timeouts++;
            $display("timeout: frame_valid never fell after the last word");
        end
    endtask

    // word goes out msb first
    task automatic push_word(input mbus_word_t w);
        for (int b = 3; b >= 0; b--) begin
            exp_q.push_back(w[b*8 +: 8]);
        end
    endtask

    task automatic compare_frame();
        check_value("frame length", got_q.size(), exp_q.size());
        for (int k = 0; k < exp_q.size() && k < got_q.size(); k++) begin
            check_value($sformatf("host_out.data[%0d]", k), 32'(got_q[k]), 32'(exp_q[k]));
        end
    endtask

    // controller model, plays the word table in order
    task automatic play_rows();
        mbus_rx_t     word;
        mbus_status_t status;
        logic         first;
        int           starts0;
        int           incs0;
        int           ends0;
        int           acks0;
        int           bytes0;
        first   = 1'b1;
        status  = '0;
        starts0 = 0;
        incs0   = 0;
        ends0   = 0;
        for (int i = 0; i < N_ROWS; i++) begin
            word = '0;
            if (rows[i].fail_only) begin
                acks0     = ack_count;
                bytes0    = got_q.size();
                starts0   = frame_starts;
                word.fail = 1'b1;
                mbus_rx <= word;
                wait_ack();
                // room for a second ack or a stray frame to show up
                repeat (12) @(posedge clk);
                check_value("fail-only rx_ack count", ack_count - acks0, 1);
                check_value("fail-only byte count", got_q.size() - bytes0, 0);
                check_value("fail-only frame count", frame_starts - starts0, 0);
            end else begin
                if (first) begin
                    got_q.delete();
                    exp_q.delete();
                    status  = '0;
                    starts0 = frame_starts;
                    incs0   = inc_count;
                    ends0   = frame_ends;
                    global_counter <= rows[i].tag;
                    exp_q.push_back(`ICE_FLAG_BYTE);
                    exp_q.push_back(rows[i].tag);
                    push_word(rows[i].addr);
                end
                push_word(rows[i].data);
                // status is the OR over the words of the message
                status.fail         = status.fail | rows[i].fail;
                status.broadcast    = status.broadcast | rows[i].broadcast;
                status.control_bits = status.control_bits | rows[i].ctrl;
                word.req          = 1'b1;
                word.pend         = rows[i].pend;
                word.fail         = rows[i].fail;
                word.broadcast    = rows[i].broadcast;
                word.control_bits = rows[i].ctrl;
                word.addr         = rows[i].addr;
                word.data         = rows[i].data;
                mbus_rx <= word;
                wait_ack();
                first = !rows[i].pend;
                if (rows[i].pend) begin
                    // req low for a cycle before the next word
                    @(posedge clk);
                end else begin
                    exp_q.push_back(host_byte_t'(status));
                    wait_frame_end(ends0);
                    compare_frame();
                    check_value("frames per message", frame_starts - starts0, 1);
                    check_value("global_counter_inc per frame", inc_count - incs0, 1);
                end
            end
        end
    endtask

    task automatic run_addr_table();
        for (int i = 0; i < N_ADDR; i++) begin
            override       <= addr_rows[i].override;
            addr_out       <= addr_rows[i].addr_in;
            addr_write     <= addr_rows[i].write;
            addr_invalid_n <= addr_rows[i].invalid_n;
            @(posedge clk);
            addr_write     <= 1'b0;
            addr_invalid_n <= 1'b1;
            @(posedge clk);
            check_value("assigned_addr", 32'(assigned_addr), 32'(addr_rows[i].exp_addr));
            check_value("assigned_addr_valid", 32'(assigned_valid),
                        32'(addr_rows[i].exp_valid));
        end
    endtask

    // clk cycles up to the next rising mbus_clk
    task automatic wait_mbus_rise(output int cycles);
        logic prev;
        logic rising;
        cycles = 0;
        rising = 1'b0;
        prev   = mbus_clk;
        do begin
            @(posedge clk);
            cycles++;
            rising = !prev && mbus_clk;
            prev   = mbus_clk;
        end while (!rising && cycles < TIMEOUT);
        if (!rising) begin
            timeouts++;
            $display("timeout: mbus_clk stopped toggling");
        end
    endtask

    task automatic measure_clk(input clk_div_t div);
        int period;
        mbus_clk_div <= div;
        // first periods after the switch may be short
        wait_mbus_rise(period);
        wait_mbus_rise(period);
        wait_mbus_rise(period);
        check_value("mbus_clk period", period, 2 * (int'(div) + 1));
    endtask

    initial begin
        void'($urandom(98231));
        fill_tables();
        reset          = 1'b1;
        mbus_rx        = '0;
        global_counter = '0;
        mbus_clk_div   = 22'd2;
        override       = `ICE_SHORT_ADDR_NONE;
        addr_out       = '0;
        addr_write     = 1'b0;
        addr_invalid_n = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        check_value("outputs in reset",
                    32'({rx_ack, host_out.frame_valid, host_out.byte_valid, gc_inc, mbus_clk}),
                    32'h0);
        @(posedge clk);

        play_rows();
        check_value("frame total", frame_starts, count_messages());
        check_value("global_counter_inc total", inc_count, count_messages());
        run_addr_table();
        measure_clk(22'd3);
        measure_clk(22'd7);
        check_value("assertion failures",
                    uut.u_rx_seq.u_props.ack_errs + uut.u_rx_seq.u_props.byte_errs +
                    uut.u_rx_seq.u_props.inc_errs, 0);

        $display("checks run %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/ice_mbus_bridge_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_mbus_bridge_properties
    import host_frame_pkg::*;
(
    input wire            clk,
    input wire            reset,
    input wire            rx_ack,
    input wire host_out_t host_out,
    input wire            global_counter_inc
);

    // failure counts per property
    int ack_errs = 0;
    int byte_errs = 0;
    int inc_errs = 0;

    // ack is a single-cycle pulse
    assert property (@(posedge clk) disable iff (reset) rx_ack |=> !rx_ack)
        else begin
            ack_errs++;
            $error("rx_ack stayed high for two cycles");
        end

    // no byte outside a frame
    assert property (@(posedge clk) disable iff (reset)
                     host_out.byte_valid |-> host_out.frame_valid)
        else begin
            byte_errs++;
            $error("byte_valid without frame_valid");
        end

    // counter bump belongs to a frame in progress
    assert property (@(posedge clk) disable iff (reset)
                     global_counter_inc |-> host_out.frame_valid)
        else begin
            inc_errs++;
            $error("global_counter_inc outside a frame");
        end

endmodule

bind rx_sequencer ice_mbus_bridge_properties u_props (
    .clk                (clk),
    .reset              (reset),
    .rx_ack             (rx_ack),
    .host_out           (host_out),
    .global_counter_inc (global_counter_inc)
);

`default_nettype wire

/* design/ice_mbus_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_mbus_bridge
    import mbus_types_pkg::*;
    import host_frame_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire mbus_rx_t    mbus_rx,
    input  wire host_byte_t  global_counter,
    input  wire clk_div_t    mbus_clk_div,
    input  wire short_addr_t mbus_short_addr_override,
    input  wire short_addr_t assigned_addr_out,
    input  wire              assigned_addr_write,
    input  wire              assigned_addr_invalid_n,
    output logic             rx_ack,
    output host_out_t        host_out,
    output logic             global_counter_inc,
    output logic             mbus_clk,
    output short_addr_t      assigned_addr,
    output logic             assigned_addr_valid
);

    // framer to shifter
    logic       load_first;
    logic       load_next;
    logic       shift;
    host_byte_t shift_byte;
    logic       shift_empty;

    mbus_clock_divider u_clk_div (
        .clk      (clk),
        .reset    (reset),
        .clk_div  (mbus_clk_div),
        .mbus_clk (mbus_clk)
    );

    // short address seen by the controller
    short_addr_register u_short_addr (
        .clk        (clk),
        .reset      (reset),
        .override   (mbus_short_addr_override),
        .addr_in    (assigned_addr_out),
        .write      (assigned_addr_write),
        .invalid_n  (assigned_addr_invalid_n),
        .addr       (assigned_addr),
        .addr_valid (assigned_addr_valid)
    );

    rx_sequencer u_rx_seq (
        .clk                (clk),
        .reset              (reset),
        .mbus_rx            (mbus_rx),
        .global_counter     (global_counter),
        .shift_byte         (shift_byte),
        .shift_empty        (shift_empty),
        .rx_ack             (rx_ack),
        .load_first         (load_first),
        .load_next          (load_next),
        .shift              (shift),
        .host_out           (host_out),
        .global_counter_inc (global_counter_inc)
    );

    // payload is held by the controller until rx_ack, sampled directly
    rx_word_shifter u_rx_shift (
        .clk         (clk),
        .reset       (reset),
        .addr        (mbus_rx.addr),
        .data        (mbus_rx.data),
        .load_first  (load_first),
        .load_next   (load_next),
        .shift       (shift),
        .shift_byte  (shift_byte),
        .shift_empty (shift_empty)
    );

endmodule

`default_nettype wire

/* rx_framer/rx_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ice_params.svh"

module rx_sequencer
    import mbus_types_pkg::*;
    import host_frame_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire mbus_rx_t   mbus_rx,
    input  wire host_byte_t global_counter,
    input  wire host_byte_t shift_byte,
    input  wire             shift_empty,
    output logic            rx_ack,
    output logic            load_first,
    output logic            load_next,
    output logic            shift,
    output host_out_t       host_out,
    output logic            global_counter_inc
);

    // two-flop synchronizers for the controller lines
    logic [1:0] req_sync;
    logic [1:0] fail_sync;
    logic       req_s;
    logic       fail_s;

    // req seen low since the last ack, blocks a stale req
    logic req_low_seen;
    // next capture takes address and data
    logic first_word;
    // current word says another one follows
    logic cur_pend;
    logic ack_q;
    logic gc_inc_q;

    mbus_status_t status_q;
    mbus_status_t word_status;
    rx_state_t    state;
    rx_state_t    next_state;

    assign req_s  = req_sync[1];
    assign fail_s = fail_sync[1];

    assign rx_ack             = ack_q;
    assign global_counter_inc = gc_inc_q;

    // status fields of the word on the bus
    always_comb begin
        word_status              = '0;
        word_status.fail         = mbus_rx.fail;
        word_status.broadcast    = mbus_rx.broadcast;
        word_status.control_bits = mbus_rx.control_bits;
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                // req wins over a fail on the same cycle
                if (req_s && req_low_seen) begin
                    next_state = st_flag;
                end else if (fail_s) begin
                    next_state = st_fail_ack;
                end
            end
            st_flag:    next_state = st_tag;
            st_tag:     next_state = st_capture;
            st_capture: next_state = st_shift;
            st_shift: begin
                if (shift_empty) begin
                    next_state = cur_pend ? st_check : st_status;
                end
            end
            st_check: begin
                // no timeout, controller owns the pace
                if (req_s && req_low_seen) begin
                    next_state = st_capture;
                end
            end
            st_status: next_state = st_idle;
            st_fail_ack: begin
                // hold until fail drops so it is acked only once
                if (!fail_s) begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_idle;
            req_sync     <= '0;
            fail_sync    <= '0;
            req_low_seen <= 1'b0;
            first_word   <= 1'b1;
            cur_pend     <= 1'b0;
            status_q     <= '0;
            ack_q        <= 1'b0;
            gc_inc_q     <= 1'b0;
        end else begin
            state     <= next_state;
            req_sync  <= {req_sync[0], mbus_rx.req};
            fail_sync <= {fail_sync[0], mbus_rx.fail};

            // ack lands in the capture cycle, or once on entry to fail_ack
            ack_q <= (next_state == st_capture) ||
                     (state == st_idle && next_state == st_fail_ack);

            // counter bump right after the tag went out
            gc_inc_q <= (state == st_tag);

            if (state == st_capture) begin
                req_low_seen <= 1'b0;
            end else if (!req_s) begin
                req_low_seen <= 1'b1;
            end

            if (state == st_idle) begin
                status_q   <= '0;
                first_word <= 1'b1;
            end else if (state == st_capture) begin
                // status is the OR over every word of the message
                status_q   <= status_q | word_status;
                first_word <= 1'b0;
                // a failed word ends the message even if pended
                cur_pend   <= mbus_rx.pend & ~mbus_rx.fail;
            end
        end
    end

    // byte source and shifter control per state
    always_comb begin
        host_out   = '0;
        load_first = 1'b0;
        load_next  = 1'b0;
        shift      = 1'b0;
        case (state)
            st_flag: begin
                host_out.frame_valid = 1'b1;
                host_out.byte_valid  = 1'b1;
                host_out.data        = `ICE_FLAG_BYTE;
            end
            st_tag: begin
                host_out.frame_valid = 1'b1;
                host_out.byte_valid  = 1'b1;
                host_out.data        = global_counter;
            end
            st_capture: begin
                host_out.frame_valid = 1'b1;
                load_first           = first_word;
                load_next            = !first_word;
            end
            st_shift: begin
                host_out.frame_valid = 1'b1;
                if (!shift_empty) begin
                    host_out.byte_valid = 1'b1;
                    host_out.data       = shift_byte;
                    shift               = 1'b1;
                end
            end
            st_check: begin
                host_out.frame_valid = 1'b1;
            end
            st_status: begin
                host_out.frame_valid = 1'b1;
                host_out.byte_valid  = 1'b1;
                host_out.data        = host_byte_t'(status_q);
            end
            default: begin
                host_out = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rx_framer/rx_word_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ice_params.svh"

module rx_word_shifter
    import mbus_types_pkg::*;
    import host_frame_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire mbus_word_t addr,
    input  wire mbus_word_t data,
    input  wire             load_first,
    input  wire             load_next,
    input  wire             shift,
    output host_byte_t      shift_byte,
    output logic            shift_empty
);

    localparam int unsigned WORD_BYTES = `ICE_MBUS_WORD_W / 8;
    localparam int unsigned SR_W       = 2 * `ICE_MBUS_WORD_W;
    // holds 0 to 2*WORD_BYTES
    localparam int unsigned CNT_W      = $clog2(2 * WORD_BYTES + 1);

    // address and data, msb first
    logic [SR_W-1:0]  sr;
    logic [CNT_W-1:0] byte_cnt;

    // payload register
    always_ff @(posedge clk) begin
        if (load_first) begin
            sr <= {addr, data};
        end else if (load_next) begin
            // later words carry data only, left aligned
            sr <= {data, {`ICE_MBUS_WORD_W{1'b0}}};
        end else if (shift) begin
            sr <= {sr[SR_W-9:0], 8'h00};
        end
    end

    // bytes still to go out
    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt <= '0;
        end else if (load_first) begin
            byte_cnt <= CNT_W'(2 * WORD_BYTES);
        end else if (load_next) begin
            byte_cnt <= CNT_W'(WORD_BYTES);
        end else if (shift && byte_cnt != '0) begin
            byte_cnt <= byte_cnt - 1'b1;
        end
    end

    assign shift_byte  = sr[SR_W-1 -: 8];
    assign shift_empty = (byte_cnt == '0);

endmodule

`default_nettype wire

/* design/short_addr_register.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ice_params.svh"

module short_addr_register
    import mbus_types_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire short_addr_t override,
    input  wire short_addr_t addr_in,
    input  wire              write,
    input  wire              invalid_n,
    output short_addr_t      addr,
    output logic             addr_valid
);

    // address assigned over the bus by the controller
    short_addr_t held_addr;
    logic        held_valid;

    // write wins over invalidate in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            held_addr  <= `ICE_SHORT_ADDR_NONE;
            held_valid <= 1'b0;
        end else if (write) begin
            held_addr  <= addr_in;
            held_valid <= 1'b1;
        end else if (!invalid_n) begin
            held_addr  <= `ICE_SHORT_ADDR_NONE;
            held_valid <= 1'b0;
        end
    end

    // host override takes precedence, anything but 0xf counts
    always_comb begin
        if (override != `ICE_SHORT_ADDR_NONE) begin
            addr       = override;
            addr_valid = 1'b1;
        end else begin
            addr       = held_addr;
            addr_valid = held_valid;
        end
    end

endmodule

`default_nettype wire

/* design/mbus_clock_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module mbus_clock_divider
    import mbus_types_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire clk_div_t clk_div,
    output logic          mbus_clk
);

    // counts clk cycles within one half period
    clk_div_t half_cnt;

    // toggle every clk_div+1 cycles, full period 2*(clk_div+1)
    always_ff @(posedge clk) begin
        if (reset) begin
            half_cnt <= '0;
            mbus_clk <= 1'b0;
        end else begin
            // >= so a divisor lowered at run time below the count
            // still ends the half period instead of wrapping
            if (half_cnt >= clk_div) begin
                half_cnt <= '0;
                mbus_clk <= ~mbus_clk;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* common/host_frame_pkg.sv */
`default_nettype none

package host_frame_pkg;

    // one byte of the host stream
    typedef logic [7:0] host_byte_t;

    // host side of the bridge, no back-pressure
    typedef struct packed {
        // high from flag byte through status byte
        logic       frame_valid;
        // single-cycle strobe per byte
        logic       byte_valid;
        host_byte_t data;
    } host_out_t;

    // receive framer states
    typedef enum logic [2:0] {
        // wait for a synchronized req or fail
        st_idle,
        // 0x62 flag byte
        st_flag,
        // time-tag byte from the global counter
        st_tag,
        // ack the word, load the shifter, merge status
        st_capture,
        // one byte per cycle out of the shifter
        st_shift,
        // wait for the next pended word
        st_check,
        // closing status byte
        st_status,
        // failed reception without req, ack only
        st_fail_ack
    } rx_state_t;

endpackage

`default_nettype wire

/* common/mbus_types_pkg.sv */
`default_nettype none

`include "ice_params.svh"

package mbus_types_pkg;

    // one address or data word from the controller
    typedef logic [`ICE_MBUS_WORD_W-1:0] mbus_word_t;

    // short address as held for the controller
    typedef logic [`ICE_SHORT_ADDR_W-1:0] short_addr_t;

    // system clock to mbus clock divisor
    typedef logic [`ICE_CLK_DIV_W-1:0] clk_div_t;

    // control bits exported by the controller with each word
    typedef logic [1:0] ctrl_bits_t;

    // receive side of the controller, valid while req is high
    typedef struct packed {
        logic       req;
        logic       pend;
        logic       fail;
        logic       broadcast;
        ctrl_bits_t control_bits;
        mbus_word_t addr;
        mbus_word_t data;
    } mbus_rx_t;

    // closing status byte of a frame, top nibble always zero
    typedef struct packed {
        logic [3:0] zero;
        logic       fail;
        logic       broadcast;
        ctrl_bits_t control_bits;
    } mbus_status_t;

endpackage

`default_nettype wire

/* common/ice_params.svh */
`ifndef ICE_PARAMS_SVH
`define ICE_PARAMS_SVH

// first byte of every host frame
`define ICE_FLAG_BYTE 8'h62

// mbus clock divisor width
`define ICE_CLK_DIV_W 22

// short address width and its "unassigned" code
`define ICE_SHORT_ADDR_W 4
`define ICE_SHORT_ADDR_NONE 4'hf

// controller word width, used for both address and data
`define ICE_MBUS_WORD_W 32

// full long address of a node
`define ICE_LONG_ADDR_W 20

`endif
